// File: decodeStage.f
+incdir+tb
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/controlDecode.sv
verilog/regFile.sv
verilog/idExLatch.sv
verilog/decodeStage.sv
tb/decodeStageTb.sv

// File: tb/decodeModel.svh
// reference model of the decode stage, included in the testbench to predict each register capture
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// one predicted capture of the decode/execute register
typedef struct packed {
	// low on a bubble, where only the gated fields are defined
	logic                    fullCheck;
	logic                    valid;
	logic                    err;
	logic [regDstWidth-1:0]  regDst;
	logic [seSelWidth-1:0]   seSel;
	logic                    regWrite;
	logic                    dMemWrite;
	logic                    dMemEn;
	logic                    aluSrc2;
	logic                    invA;
	logic                    invB;
	logic                    cin;
	logic                    pcSrc;
	logic                    pcImm;
	logic                    branching;
	logic                    memToReg;
	logic                    dump;
	logic                    jump;
	logic [dataWidth-1:0]    rsData;
	logic [dataWidth-1:0]    rtData;
	logic [dataWidth-1:0]    imm;
	logic [dataWidth-1:0]    pcPlus2;
	logic [regAddrWidth-1:0] writeReg;
} decodeExpect;

// regs is the register view the DUT reads, same-edge writeback already applied
function automatic decodeExpect predictDecode(
	input logic                      valid,
	input logic [instrWidth-1:0]     word,
	input logic [dataWidth-1:0]      pc,
	input logic [7:0][dataWidth-1:0] regs
);
	decodeExpect e;
	logic [opcodeWidth-1:0] op;
	logic [functWidth-1:0] fn;
	logic signed [dataWidth-1:0] ext;
	op = word[15:11];
	fn = word[1:0];
	e = '0;
	e.regWrite = 1'b1;
	e.aluSrc2  = 1'b1;
	e.regDst   = dstRd;
	e.seSel    = seZext5;
	case (op)
		aluArith: begin
			e.invA = (fn == fnSub);
			e.cin  = (fn == fnSub);
		end
		opSeq, opSlt, opSle: begin
			e.invB = 1'b1;
			e.cin  = 1'b1;
		end
		aluShift, opBtr, opSco: ;
		// immediate alu, only SUBI and ADDI sign-extend
		opSubi, opAddi, opAndni, opXori, opRoli, opSlli, opRori, opSrli: begin
			e.aluSrc2 = 1'b0;
			e.regDst  = dstI1;
			if (op == opSubi || op == opAddi) e.seSel = seSext5;
			e.invA = (op == opSubi);
			e.cin  = (op == opSubi);
			e.invB = (op == opAndni);
		end
		opSt, opLd, opStu: begin
			e.aluSrc2   = 1'b0;
			e.regDst    = (op == opStu) ? dstRs : dstI1;
			e.seSel     = seSext5;
			e.dMemEn    = 1'b1;
			e.dMemWrite = (op != opLd);
			e.memToReg  = (op == opLd);
			e.regWrite  = (op != opSt);
		end
		opBnez, opBeqz, opBltz, opBgez: begin
			e.seSel     = seSext8;
			e.pcSrc     = 1'b1;
			e.branching = 1'b1;
			e.aluSrc2   = 1'b0;
			e.regWrite  = 1'b0;
		end
		opLbi, opSlbi: begin
			e.seSel   = (op == opLbi) ? seSext8 : seZext8;
			e.regDst  = dstRs;
			e.aluSrc2 = 1'b0;
		end
		opJr, opJalr: begin
			e.seSel    = seSext8;
			e.jump     = 1'b1;
			e.pcSrc    = 1'b1;
			e.regWrite = (op == opJalr);
			if (op == opJalr) e.regDst = dstLink;
		end
		opJ, opJal: begin
			e.seSel    = seSext11;
			e.pcImm    = 1'b1;
			e.pcSrc    = 1'b1;
			e.regWrite = (op == opJal);
			if (op == opJal) e.regDst = dstLink;
		end
		opNop: e.regWrite = 1'b0;
		opHalt: begin
			e.regWrite = 1'b0;
			e.dump     = 1'b1;
		end
		opRti: begin
			e.regWrite = 1'b0;
			e.pcSrc    = 1'b1;
		end
		opSiic: ;
		default: e.err = 1'b1;
	endcase
	// unsigned slices zero-extend, $signed slices sign-extend
	case (e.seSel)
		seZext5:  ext = word[4:0];
		seZext8:  ext = word[7:0];
		seSext5:  ext = $signed(word[4:0]);
		seSext8:  ext = $signed(word[7:0]);
		seSext11: ext = $signed(word[10:0]);
		default:  ext = '0;
	endcase
	e.imm = ext;
	case (e.regDst)
		dstRd:   e.writeReg = word[4:2];
		dstI1:   e.writeReg = word[7:5];
		dstRs:   e.writeReg = word[10:8];
		default: e.writeReg = 3'd7;
	endcase
	e.rsData  = regs[word[10:8]];
	e.rtData  = regs[word[7:5]];
	e.pcPlus2 = pc;
	// a bubble carries no state change
	e.valid     = valid;
	e.fullCheck = valid;
	e.err       = e.err & valid;
	e.regWrite  = e.regWrite & valid;
	e.dMemWrite = e.dMemWrite & valid;
	e.dMemEn    = e.dMemEn & valid;
	e.pcSrc     = e.pcSrc & valid;
	e.branching = e.branching & valid;
	e.dump      = e.dump & valid;
	e.jump      = e.jump & valid;
	return e;
endfunction

`endif

// File: tb/decodeStageTb.sv
// decode stage testbench driving random instructions, stalls and writebacks against the model
module decodeStageTb;

	import isaPkg::*;
	import ctrlPkg::*;

	localparam int dataWidth  = 16;
	localparam int drainLimit = 20;

	// DUT inputs
	logic                    clk;
	logic                    rstN;
	logic                    instrValid;
	instrWord                instr;
	logic [dataWidth-1:0]    pcPlus2;
	logic                    stall;
	logic                    wbEn;
	logic [regAddrWidth-1:0] wbAddr;
	logic [dataWidth-1:0]    wbData;

	// DUT outputs
	logic exValid, exErr, exRegWrite, exDMemWrite, exDMemEn, exAluSrc2, exInvA, exInvB;
	logic exCin, exPcSrc, exPcImm, exBranching, exMemToReg, exDump, exJump;
	logic [regDstWidth-1:0]  exRegDst;
	logic [seSelWidth-1:0]   exSeSel;
	logic [dataWidth-1:0]    exRsData;
	logic [dataWidth-1:0]    exRtData;
	logic [dataWidth-1:0]    exImm;
	logic [dataWidth-1:0]    exPcPlus2;
	logic [regAddrWidth-1:0] exWriteReg;

	`include "decodeModel.svh"

	integer seed;
	int valErrs;
	int otherErrs;
	int edgesChecked;
	// register contents as written by this testbench
	logic [7:0][dataWidth-1:0] shadow;
	decodeExpect held;
	decodeExpect expQ[$];

	decodeStage #(.dataWidth(dataWidth)) u_decodeStage (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkField(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) else begin
			valErrs++;
			$display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic checkOutputs(input decodeExpect e);
		// valid and the gated controls are defined for bubbles too
		checkField("exValid", exValid, e.valid);
		checkField("exErr", exErr, e.err);
		checkField("exRegWrite", exRegWrite, e.regWrite);
		checkField("exDMemWrite", exDMemWrite, e.dMemWrite);
		checkField("exDMemEn", exDMemEn, e.dMemEn);
		checkField("exPcSrc", exPcSrc, e.pcSrc);
		checkField("exBranching", exBranching, e.branching);
		checkField("exDump", exDump, e.dump);
		checkField("exJump", exJump, e.jump);
		if (e.fullCheck) begin
			checkField("exRegDst", exRegDst, e.regDst);
			checkField("exSeSel", exSeSel, e.seSel);
			checkField("exAluSrc2", exAluSrc2, e.aluSrc2);
			checkField("exInvA", exInvA, e.invA);
			checkField("exInvB", exInvB, e.invB);
			checkField("exCin", exCin, e.cin);
			checkField("exPcImm", exPcImm, e.pcImm);
			checkField("exMemToReg", exMemToReg, e.memToReg);
			checkField("exRsData", exRsData, e.rsData);
			checkField("exRtData", exRtData, e.rtData);
			checkField("exImm", exImm, e.imm);
			checkField("exPcPlus2", exPcPlus2, e.pcPlus2);
			checkField("exWriteReg", exWriteReg, e.writeReg);
		end
	endtask

	//////////////////////////////////////////////////
	// compare process
	//////////////////////////////////////////////////

	// outputs seen at an edge hold the capture of the edge before
	always @(posedge clk) begin
		logic [7:0][dataWidth-1:0] view;
		if (expQ.size() > 0) held = expQ.pop_front();
		if (rstN) begin
			checkOutputs(held);
			edgesChecked++;
			// same-edge writeback is forwarded to both read ports
			view = shadow;
			if (wbEn) view[wbAddr] = wbData;
			// stalled edges drop the instruction, so the held capture stays expected
			if (!stall) expQ.push_back(predictDecode(instrValid, instr, pcPlus2, view));
			shadow = view;
		end
	end

	// one instruction slot plus a random writeback
	task automatic driveCycle(input logic [instrWidth-1:0] word, input logic v, input logic s);
		logic [31:0] r;
		logic [regAddrWidth-1:0] addr;
		r = $random(seed);
		addr = r[2:0];
		// aim some writes at the registers this word reads
		if (r[5:4] == 2'd1) addr = word[10:8];
		if (r[5:4] == 2'd2) addr = word[7:5];
		@(posedge clk);
		instr      <= word;
		instrValid <= v;
		stall      <= s;
		pcPlus2    <= r[31:16];
		wbEn       <= r[8];
		wbAddr     <= addr;
		r = $random(seed);
		wbData     <= r[dataWidth-1:0];
	endtask

	initial begin
		logic [31:0] r;
		logic [instrWidth-1:0] word;
		int target;
		int waited;
		seed = 32'h1595081b;
		valErrs = 0;
		otherErrs = 0;
		edgesChecked = 0;
		shadow = '0;
		held = '0;
		// the reset state has every output at zero
		held.fullCheck = 1'b1;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pcPlus2 = '0;
		stall = 1'b0;
		wbEn = 1'b0;
		wbAddr = '0;
		wbData = '0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		// every opcode with every funct and random operand fields
		for (int op = 0; op < 32; op++) begin
			for (int fn = 0; fn < 4; fn++) begin
				r = $random(seed);
				word = r[15:0];
				word[15:11] = op[4:0];
				word[1:0] = fn[1:0];
				driveCycle(word, 1'b1, 1'b0);
			end
		end

		// random words of every format, both immediate signs, all destinations
		repeat (300) begin
			r = $random(seed);
			driveCycle(r[15:0], 1'b1, 1'b0);
		end

		// stall about one edge in four, bubble about one slot in four
		repeat (300) begin
			r = $random(seed);
			driveCycle(r[15:0], r[17:16] != 2'd0, r[19:18] == 2'd0);
		end

		// drain with a bubble until the last capture is checked
		@(posedge clk);
		instrValid <= 1'b0;
		stall      <= 1'b0;
		wbEn       <= 1'b0;
		@(negedge clk);
		target = edgesChecked + 2;
		waited = 0;
		while (edgesChecked < target && waited < drainLimit) begin
			@(negedge clk);
			waited++;
		end
		assert (edgesChecked >= target) else begin
			otherErrs++;
			$display("timed out waiting for the last captures to be checked");
		end

		$display("checks done with %0d value errors and %0d other errors", valErrs, otherErrs);
		if (valErrs + otherErrs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: verilog/decodeStage.sv
// decode stage top, connects the opcode decoder, register file and decode/execute register
module decodeStage #(
	parameter int dataWidth = 16
) (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            instrValid,
	input  isaPkg::instrWord                instr,
	input  logic [dataWidth-1:0]            pcPlus2,
	input  logic                            stall,
	input  logic                            wbEn,
	input  logic [isaPkg::regAddrWidth-1:0] wbAddr,
	input  logic [dataWidth-1:0]            wbData,
	output logic                            exValid,
	output logic                            exErr,
	output logic [ctrlPkg::regDstWidth-1:0] exRegDst,
	output logic [ctrlPkg::seSelWidth-1:0]  exSeSel,
	output logic                            exRegWrite,
	output logic                            exDMemWrite,
	output logic                            exDMemEn,
	output logic                            exAluSrc2,
	output logic                            exInvA,
	output logic                            exInvB,
	output logic                            exCin,
	output logic                            exPcSrc,
	output logic                            exPcImm,
	output logic                            exBranching,
	output logic                            exMemToReg,
	output logic                            exDump,
	output logic                            exJump,
	output logic [dataWidth-1:0]            exRsData,
	output logic [dataWidth-1:0]            exRtData,
	output logic [dataWidth-1:0]            exImm,
	output logic [dataWidth-1:0]            exPcPlus2,
	output logic [isaPkg::regAddrWidth-1:0] exWriteReg
);

	import ctrlPkg::*;

	// decoder levels into the pipeline register
	logic [regDstWidth-1:0] regDst;
	logic [seSelWidth-1:0]  seSel;
	logic regWrite, dMemWrite, dMemEn, aluSrc2, invA, invB, cin;
	logic pcSrc, pcImm, branching, memToReg, dump, jump, illegal;

	// source operands
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;

	controlDecode u_controlDecode (
		.opcode    (instr.rFmt.opcode),
		.funct     (instr.rFmt.funct),
		.regDst    (regDst),
		.seSel     (seSel),
		.regWrite  (regWrite),
		.dMemWrite (dMemWrite),
		.dMemEn    (dMemEn),
		.aluSrc2   (aluSrc2),
		.invA      (invA),
		.invB      (invB),
		.cin       (cin),
		.pcSrc     (pcSrc),
		.pcImm     (pcImm),
		.branching (branching),
		.memToReg  (memToReg),
		.dump      (dump),
		.jump      (jump),
		.illegal   (illegal)
	);

	// rs and rt sit in the same bits for every format that reads them
	regFile #(.dataWidth(dataWidth)) u_regFile (
		.clk    (clk),
		.rstN   (rstN),
		.rsAddr (instr.rFmt.rs),
		.rtAddr (instr.rFmt.rt),
		.wbEn   (wbEn),
		.wbAddr (wbAddr),
		.wbData (wbData),
		.rsData (rsData),
		.rtData (rtData)
	);

	idExLatch #(.dataWidth(dataWidth)) u_idExLatch (
		.clk         (clk),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.stall       (stall),
		.instr       (instr),
		.pcPlus2     (pcPlus2),
		.rsData      (rsData),
		.rtData      (rtData),
		.regDst      (regDst),
		.seSel       (seSel),
		.regWrite    (regWrite),
		.dMemWrite   (dMemWrite),
		.dMemEn      (dMemEn),
		.aluSrc2     (aluSrc2),
		.invA        (invA),
		.invB        (invB),
		.cin         (cin),
		.pcSrc       (pcSrc),
		.pcImm       (pcImm),
		.branching   (branching),
		.memToReg    (memToReg),
		.dump        (dump),
		.jump        (jump),
		.illegal     (illegal),
		.exValid     (exValid),
		.exErr       (exErr),
		.exRegDst    (exRegDst),
		.exSeSel     (exSeSel),
		.exRegWrite  (exRegWrite),
		.exDMemWrite (exDMemWrite),
		.exDMemEn    (exDMemEn),
		.exAluSrc2   (exAluSrc2),
		.exInvA      (exInvA),
		.exInvB      (exInvB),
		.exCin       (exCin),
		.exPcSrc     (exPcSrc),
		.exPcImm     (exPcImm),
		.exBranching (exBranching),
		.exMemToReg  (exMemToReg),
		.exDump      (exDump),
		.exJump      (exJump),
		.exRsData    (exRsData),
		.exRtData    (exRtData),
		.exImm       (exImm),
		.exPcPlus2   (exPcPlus2),
		.exWriteReg  (exWriteReg)
	);

endmodule

// File: verilog/idExLatch.sv
// immediate extension, destination select and the decode/execute pipeline register
module idExLatch #(
	parameter int dataWidth = 16
) (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            instrValid,
	input  logic                            stall,
	input  isaPkg::instrWord                instr,
	input  logic [dataWidth-1:0]            pcPlus2,
	input  logic [dataWidth-1:0]            rsData,
	input  logic [dataWidth-1:0]            rtData,
	input  logic [ctrlPkg::regDstWidth-1:0] regDst,
	input  logic [ctrlPkg::seSelWidth-1:0]  seSel,
	input  logic                            regWrite,
	input  logic                            dMemWrite,
	input  logic                            dMemEn,
	input  logic                            aluSrc2,
	input  logic                            invA,
	input  logic                            invB,
	input  logic                            cin,
	input  logic                            pcSrc,
	input  logic                            pcImm,
	input  logic                            branching,
	input  logic                            memToReg,
	input  logic                            dump,
	input  logic                            jump,
	input  logic                            illegal,
	output logic                            exValid,
	output logic                            exErr,
	output logic [ctrlPkg::regDstWidth-1:0] exRegDst,
	output logic [ctrlPkg::seSelWidth-1:0]  exSeSel,
	output logic                            exRegWrite,
	output logic                            exDMemWrite,
	output logic                            exDMemEn,
	output logic                            exAluSrc2,
	output logic                            exInvA,
	output logic                            exInvB,
	output logic                            exCin,
	output logic                            exPcSrc,
	output logic                            exPcImm,
	output logic                            exBranching,
	output logic                            exMemToReg,
	output logic                            exDump,
	output logic                            exJump,
	output logic [dataWidth-1:0]            exRsData,
	output logic [dataWidth-1:0]            exRtData,
	output logic [dataWidth-1:0]            exImm,
	output logic [dataWidth-1:0]            exPcPlus2,
	output logic [isaPkg::regAddrWidth-1:0] exWriteReg
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic [dataWidth-1:0]    immExt;
	logic [regAddrWidth-1:0] writeReg;

	// immediate through the format view the extension implies
	always_comb begin
		case (seSel)
			seZext5:  immExt = {{(dataWidth-5){1'b0}}, instr.iFmt1.imm5};
			seZext8:  immExt = {{(dataWidth-8){1'b0}}, instr.iFmt2.imm8};
			seSext5:  immExt = {{(dataWidth-5){instr.iFmt1.imm5[4]}}, instr.iFmt1.imm5};
			seSext8:  immExt = {{(dataWidth-8){instr.iFmt2.imm8[7]}}, instr.iFmt2.imm8};
			seSext11: immExt = {{(dataWidth-11){instr.jFmt.disp11[10]}}, instr.jFmt.disp11};
			default:  immExt = '0;
		endcase
	end

	always_comb begin
		case (regDst)
			dstRd:   writeReg = instr.rFmt.rd;
			dstI1:   writeReg = instr.iFmt1.rd;
			dstRs:   writeReg = instr.rFmt.rs;
			default: writeReg = {regAddrWidth{1'b1}};
		endcase
	end

	//////////////////////////////////////////////////
	// pipeline register
	//////////////////////////////////////////////////

	// stall holds every field, a bubble clears the gated controls
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid     <= 1'b0;
			exErr       <= 1'b0;
			exRegDst    <= '0;
			exSeSel     <= '0;
			exRegWrite  <= 1'b0;
			exDMemWrite <= 1'b0;
			exDMemEn    <= 1'b0;
			exAluSrc2   <= 1'b0;
			exInvA      <= 1'b0;
			exInvB      <= 1'b0;
			exCin       <= 1'b0;
			exPcSrc     <= 1'b0;
			exPcImm     <= 1'b0;
			exBranching <= 1'b0;
			exMemToReg  <= 1'b0;
			exDump      <= 1'b0;
			exJump      <= 1'b0;
			exRsData    <= '0;
			exRtData    <= '0;
			exImm       <= '0;
			exPcPlus2   <= '0;
			exWriteReg  <= '0;
		end else if (!stall) begin
			exValid     <= instrValid;
			exErr       <= illegal & instrValid;
			// state-changing controls never fire for a bubble
			exRegWrite  <= regWrite & instrValid;
			exDMemWrite <= dMemWrite & instrValid;
			exDMemEn    <= dMemEn & instrValid;
			exPcSrc     <= pcSrc & instrValid;
			exBranching <= branching & instrValid;
			exJump      <= jump & instrValid;
			// memory dump on HALT, valid-gated instead of reset-gated
			exDump      <= dump & instrValid;
			// don't-care when the slot is empty
			exRegDst    <= regDst;
			exSeSel     <= seSel;
			exAluSrc2   <= aluSrc2;
			exInvA      <= invA;
			exInvB      <= invB;
			exCin       <= cin;
			exPcImm     <= pcImm;
			exMemToReg  <= memToReg;
			exRsData    <= rsData;
			exRtData    <= rtData;
			exImm       <= immExt;
			exPcPlus2   <= pcPlus2;
			exWriteReg  <= writeReg;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) exErr |-> exValid);

endmodule

// File: verilog/regFile.sv
// eight-entry register file, two read ports with write-through and one writeback port
module regFile #(
	parameter int dataWidth = 16
) (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic [isaPkg::regAddrWidth-1:0] rsAddr,
	input  logic [isaPkg::regAddrWidth-1:0] rtAddr,
	input  logic                            wbEn,
	input  logic [isaPkg::regAddrWidth-1:0] wbAddr,
	input  logic [dataWidth-1:0]            wbData,
	output logic [dataWidth-1:0]            rsData,
	output logic [dataWidth-1:0]            rtData
);

	import isaPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	logic [dataWidth-1:0] regs [numRegs];

	// write port, all registers clear on reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn) begin
			regs[wbAddr] <= wbData;
		end
	end

	// a same-cycle writeback to the read address is forwarded
	always_comb begin
		rsData = regs[rsAddr];
		rtData = regs[rtAddr];
		if (wbEn && (wbAddr == rsAddr)) begin
			rsData = wbData;
		end
		if (wbEn && (wbAddr == rtAddr)) begin
			rtData = wbData;
		end
	end

	// writeback stage must present a clean address with its enable
	assert property (@(posedge clk) disable iff (!rstN) wbEn |-> !$isunknown(wbAddr));

endmodule

// File: verilog/controlDecode.sv
// combinational opcode/funct decoder, drives the control levels of the decode stage
module controlDecode (
	input  logic [isaPkg::opcodeWidth-1:0]  opcode,
	input  logic [isaPkg::functWidth-1:0]   funct,
	output logic [ctrlPkg::regDstWidth-1:0] regDst,
	output logic [ctrlPkg::seSelWidth-1:0]  seSel,
	output logic                            regWrite,
	output logic                            dMemWrite,
	output logic                            dMemEn,
	output logic                            aluSrc2,
	output logic                            invA,
	output logic                            invB,
	output logic                            cin,
	output logic                            pcSrc,
	output logic                            pcImm,
	output logic                            branching,
	output logic                            memToReg,
	output logic                            dump,
	output logic                            jump,
	output logic                            illegal
);

	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		// most instructions write a register and take rt as operand 2
		regWrite  = 1'b1;
		aluSrc2   = 1'b1;
		regDst    = dstRd;
		seSel     = seZext5;
		dMemWrite = 1'b0;
		dMemEn    = 1'b0;
		invA      = 1'b0;
		invB      = 1'b0;
		cin       = 1'b0;
		pcSrc     = 1'b0;
		pcImm     = 1'b0;
		branching = 1'b0;
		memToReg  = 1'b0;
		dump      = 1'b0;
		jump      = 1'b0;
		illegal   = 1'b0;

		case (opcode)
			//////////////////////////////////////////////////
			// register format
			//////////////////////////////////////////////////
			aluArith: begin
				regDst = dstRd;
				// subtract as ~rs + rt + 1
				if (funct == fnSub) begin
					invA = 1'b1;
					cin  = 1'b1;
				end
			end
			// compares subtract rt from rs
			opSeq, opSlt, opSle: begin
				regDst = dstRd;
				invB   = 1'b1;
				cin    = 1'b1;
			end
			aluShift, opSco, opBtr: regDst = dstRd;

			//////////////////////////////////////////////////
			// immediate format 1
			//////////////////////////////////////////////////
			opSubi: begin
				aluSrc2 = 1'b0;
				regDst  = dstI1;
				seSel   = seSext5;
				invA    = 1'b1;
				cin     = 1'b1;
			end
			opAddi: begin
				aluSrc2 = 1'b0;
				regDst  = dstI1;
				seSel   = seSext5;
			end
			opAndni: begin
				aluSrc2 = 1'b0;
				regDst  = dstI1;
				invB    = 1'b1;
			end
			// logic and shift immediates keep the zero-extended imm5
			opXori, opRoli, opSlli, opRori, opSrli: begin
				aluSrc2 = 1'b0;
				regDst  = dstI1;
			end
			opSt: begin
				aluSrc2   = 1'b0;
				regDst    = dstI1;
				seSel     = seSext5;
				dMemEn    = 1'b1;
				dMemWrite = 1'b1;
				regWrite  = 1'b0;
			end
			opLd: begin
				aluSrc2  = 1'b0;
				regDst   = dstI1;
				seSel    = seSext5;
				dMemEn   = 1'b1;
				memToReg = 1'b1;
			end
			// store with update writes the new address back to rs
			opStu: begin
				aluSrc2   = 1'b0;
				regDst    = dstRs;
				seSel     = seSext5;
				dMemEn    = 1'b1;
				dMemWrite = 1'b1;
			end

			//////////////////////////////////////////////////
			// immediate format 2 and jumps
			//////////////////////////////////////////////////
			opBnez, opBeqz, opBltz, opBgez: begin
				seSel     = seSext8;
				pcSrc     = 1'b1;
				branching = 1'b1;
				aluSrc2   = 1'b0;
				regWrite  = 1'b0;
			end
			opLbi: begin
				seSel   = seSext8;
				regDst  = dstRs;
				aluSrc2 = 1'b0;
			end
			opSlbi: begin
				seSel   = seZext8;
				regDst  = dstRs;
				aluSrc2 = 1'b0;
			end
			// JALR links through r7
			opJr, opJalr: begin
				seSel    = seSext8;
				jump     = 1'b1;
				pcSrc    = 1'b1;
				regWrite = (opcode == opJalr);
				regDst   = (opcode == opJalr) ? dstLink : dstRd;
			end
			// pc-relative, target is pc + 2 + disp11
			opJ, opJal: begin
				seSel    = seSext11;
				pcImm    = 1'b1;
				pcSrc    = 1'b1;
				regWrite = (opcode == opJal);
				regDst   = (opcode == opJal) ? dstLink : dstRd;
			end

			// special
			opNop: regWrite = 1'b0;
			opHalt: begin
				regWrite = 1'b0;
				dump     = 1'b1;
			end
			// return from interrupt restores the pc
			opRti: begin
				regWrite = 1'b0;
				pcSrc    = 1'b1;
			end
			opSiic: ;
			default: illegal = 1'b1;
		endcase
	end

	// every store enables memory, every branch redirects the pc
	assert final (!dMemWrite || dMemEn);
	assert final (!branching || pcSrc);

endmodule

// File: verilog/ctrlPkg.sv
// control field encodings passed from the opcode decoder to the decode/execute register
package ctrlPkg;

	localparam int seSelWidth  = 3;
	localparam int regDstWidth = 2;

	//////////////////////////////////////////////////
	// immediate extension select
	//////////////////////////////////////////////////

	// unlisted codes extend nothing and give zero
	localparam logic [seSelWidth-1:0] seZext5  = 3'b000;
	localparam logic [seSelWidth-1:0] seZext8  = 3'b001;
	localparam logic [seSelWidth-1:0] seSext5  = 3'b010;
	localparam logic [seSelWidth-1:0] seSext8  = 3'b100;
	localparam logic [seSelWidth-1:0] seSext11 = 3'b110;

	//////////////////////////////////////////////////
	// destination register select
	//////////////////////////////////////////////////

	// rd of the register format
	localparam logic [regDstWidth-1:0] dstRd   = 2'b00;
	// rd of immediate format 1
	localparam logic [regDstWidth-1:0] dstI1   = 2'b01;
	// rs, for LBI, SLBI and STU
	localparam logic [regDstWidth-1:0] dstRs   = 2'b10;
	// r7 holds the return address of JAL and JALR
	localparam logic [regDstWidth-1:0] dstLink = 2'b11;

endpackage

// File: verilog/isaPkg.sv
// instruction set encodings and the instruction word views, imported by every decode block
package isaPkg;

	// field widths
	localparam int opcodeWidth  = 5;
	localparam int functWidth   = 2;
	localparam int instrWidth   = 16;
	localparam int regAddrWidth = 3;

	//////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////

	// special
	localparam logic [opcodeWidth-1:0] opHalt  = 5'b00000;
	localparam logic [opcodeWidth-1:0] opNop   = 5'b00001;
	localparam logic [opcodeWidth-1:0] opSiic  = 5'b00010;
	localparam logic [opcodeWidth-1:0] opRti   = 5'b00011;

	// jumps, J and JAL carry an 11-bit displacement
	localparam logic [opcodeWidth-1:0] opJ     = 5'b00100;
	localparam logic [opcodeWidth-1:0] opJr    = 5'b00101;
	localparam logic [opcodeWidth-1:0] opJal   = 5'b00110;
	localparam logic [opcodeWidth-1:0] opJalr  = 5'b00111;

	// immediate alu, format 1
	localparam logic [opcodeWidth-1:0] opSubi  = 5'b01000;
	localparam logic [opcodeWidth-1:0] opAddi  = 5'b01001;
	localparam logic [opcodeWidth-1:0] opAndni = 5'b01010;
	localparam logic [opcodeWidth-1:0] opXori  = 5'b01011;
	localparam logic [opcodeWidth-1:0] opRoli  = 5'b10100;
	localparam logic [opcodeWidth-1:0] opSlli  = 5'b10101;
	localparam logic [opcodeWidth-1:0] opRori  = 5'b10110;
	localparam logic [opcodeWidth-1:0] opSrli  = 5'b10111;

	// branches test rs against zero
	localparam logic [opcodeWidth-1:0] opBnez  = 5'b01100;
	localparam logic [opcodeWidth-1:0] opBeqz  = 5'b01101;
	localparam logic [opcodeWidth-1:0] opBltz  = 5'b01110;
	localparam logic [opcodeWidth-1:0] opBgez  = 5'b01111;

	// memory and byte loads
	localparam logic [opcodeWidth-1:0] opSt    = 5'b10000;
	localparam logic [opcodeWidth-1:0] opLd    = 5'b10001;
	localparam logic [opcodeWidth-1:0] opSlbi  = 5'b10010;
	localparam logic [opcodeWidth-1:0] opStu   = 5'b10011;
	localparam logic [opcodeWidth-1:0] opLbi   = 5'b11000;

	// register format
	localparam logic [opcodeWidth-1:0] opBtr    = 5'b11001;
	localparam logic [opcodeWidth-1:0] aluShift = 5'b11010;
	localparam logic [opcodeWidth-1:0] aluArith = 5'b11011;
	localparam logic [opcodeWidth-1:0] opSeq    = 5'b11100;
	localparam logic [opcodeWidth-1:0] opSlt    = 5'b11101;
	localparam logic [opcodeWidth-1:0] opSle    = 5'b11110;
	localparam logic [opcodeWidth-1:0] opSco    = 5'b11111;

	// funct codes within aluArith
	localparam logic [functWidth-1:0] fnAdd  = 2'b00;
	localparam logic [functWidth-1:0] fnSub  = 2'b01;
	localparam logic [functWidth-1:0] fnXor  = 2'b10;
	localparam logic [functWidth-1:0] fnAndn = 2'b11;

	// funct codes within aluShift
	localparam logic [functWidth-1:0] fnRol = 2'b00;
	localparam logic [functWidth-1:0] fnSll = 2'b01;
	localparam logic [functWidth-1:0] fnRor = 2'b10;
	localparam logic [functWidth-1:0] fnSrl = 2'b11;

	//////////////////////////////////////////////////
	// instruction word, opcode always in 15:11
	//////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [opcodeWidth-1:0]  opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [regAddrWidth-1:0] rd;
			logic [functWidth-1:0]   funct;
		} rFmt;
		struct packed {
			logic [opcodeWidth-1:0]  opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rd;
			logic [4:0]              imm5;
		} iFmt1;
		struct packed {
			logic [opcodeWidth-1:0]  opcode;
			logic [regAddrWidth-1:0] rs;
			logic [7:0]              imm8;
		} iFmt2;
		struct packed {
			logic [opcodeWidth-1:0]  opcode;
			logic [10:0]             disp11;
		} jFmt;
	} instrWord;

endpackage
